/* verilog/pow_types_pkg.sv */
`default_nettype none

package pow_types_pkg;

    // --------------------------------------------------
    // Widths
    // --------------------------------------------------

    // Default operand width that the top level may override
    localparam int w_operand = 8;

    localparam int w_opcode  = 2;

    // Room for the fifth power of the widest operand
    localparam int w_value   = 5 * w_operand;

    // --------------------------------------------------
    // Opcodes and payloads
    // --------------------------------------------------

    // Exponent is the encoding plus two
    typedef enum logic [w_opcode - 1:0] {
        op_square = 2'd0,
        op_cube   = 2'd1,
        op_fourth = 2'd2,
        op_fifth  = 2'd3
    } pow_opcode_e;

    typedef struct packed {
        pow_opcode_e            opcode;
        logic [w_operand - 1:0] operand;
    } pow_request_t;

    typedef struct packed {
        pow_opcode_e            opcode;
        logic [w_operand - 1:0] operand;
        logic [w_value   - 1:0] value;
    } pow_result_t;

    function automatic logic [2:0] pow_exponent(pow_opcode_e opcode);
        return 3'(opcode) + 3'd2;
    endfunction

endpackage

`default_nettype wire

/* verilog/apb_pkg.sv */
`default_nettype none

package apb_pkg;

    localparam int w_addr = 4;
    localparam int w_data = 32;

    // Master to slave
    typedef struct packed {
        logic                psel;
        logic                penable;
        logic                pwrite;
        logic [w_addr - 1:0] paddr;
        logic [w_data - 1:0] pwdata;
    } apb_req_t;

    // Slave to master
    typedef struct packed {
        logic [w_data - 1:0] prdata;
        logic                pready;
        logic                pslverr;
    } apb_rsp_t;

    // Register map with a write-only request and a read-only status
    typedef enum logic [w_addr - 1:0] {
        addr_request = 4'h0,
        addr_status  = 4'h4
    } apb_addr_e;

endpackage

`default_nettype wire

/* verilog/apb_request_port.sv */
`default_nettype none

module apb_request_port
# (
    parameter int w_operand  = pow_types_pkg::w_operand,
    parameter int fifo_depth = 4
)
(
    input  logic                         slow_clk,
    input  logic                         rst,

    input  apb_pkg::apb_req_t            apb_req,
    output apb_pkg::apb_rsp_t            apb_rsp,

    input  logic                         full,
    input  logic [$clog2(fifo_depth):0]  count,
    output logic                         push,
    output pow_types_pkg::pow_request_t  push_data
);

    localparam int w_count     = $clog2(fifo_depth) + 1;
    localparam int opcode_lsb  = 0;
    localparam int operand_lsb = 2;

    logic req_write;
    logic status_read;
    logic illegal;
    logic access;
    logic done;
    logic pready_q;

    // --------------------------------------------------
    // Address decode
    // --------------------------------------------------

    always_comb begin
        req_write   = 1'b0;
        status_read = 1'b0;

        case (apb_req.paddr)
            apb_pkg::addr_request: req_write   =  apb_req.pwrite;
            apb_pkg::addr_status:  status_read = !apb_req.pwrite;
            default: ;
        endcase
    end

    // Wrong direction or unknown address
    assign illegal = !req_write && !status_read;

    assign access  = apb_req.psel && apb_req.penable;
    assign done    = access && pready_q;

    // --------------------------------------------------
    // Ready
    // --------------------------------------------------

    // Decided one edge ahead, so setup sees the fill level first.
    // Only our own push can fill the FIFO in between.
    always_ff @ (posedge slow_clk or posedge rst)
        if (rst)
            pready_q <= 1'b0;
        else
            pready_q <= apb_req.psel && !done && !(req_write && full);

    // Response
    always_comb begin
        apb_rsp         = '0;
        apb_rsp.pready  = pready_q;
        apb_rsp.pslverr = done && illegal;

        if (status_read)
            apb_rsp.prdata[w_count - 1:0] = count;
    end

    // Pack write data into a request
    assign push               = done && req_write;
    assign push_data.opcode   = pow_types_pkg::pow_opcode_e'(apb_req.pwdata[opcode_lsb +: 2]);
    assign push_data.operand  = apb_req.pwdata[operand_lsb +: w_operand];

endmodule

`default_nettype wire

/* verilog/request_fifo.sv */
`default_nettype none

module request_fifo
# (
    parameter int w_operand  = pow_types_pkg::w_operand,
    parameter int fifo_depth = 4
)
(
    input  logic                         slow_clk,
    input  logic                         rst,

    input  logic                         push,
    input  pow_types_pkg::pow_request_t  push_data,
    input  logic                         pop,

    output pow_types_pkg::pow_request_t  head,
    output logic                         empty,
    output logic                         full,
    output logic [$clog2(fifo_depth):0]  count
);

    localparam int w_ptr   = $clog2(fifo_depth);
    localparam int w_count = w_ptr + 1;
    localparam int w_entry = $bits(pow_types_pkg::pow_opcode_e) + w_operand;

    logic [w_entry - 1:0] mem [fifo_depth];

    logic [w_ptr   - 1:0] wr_ptr;
    logic [w_ptr   - 1:0] rd_ptr;
    logic [w_count - 1:0] fill;

    logic do_push;
    logic do_pop;

    assign do_push = push && !full;
    assign do_pop  = pop  && !empty;

    // --------------------------------------------------
    // Pointers and fill level
    // --------------------------------------------------

    // Pointers wrap by themselves since depth is a power of two
    always_ff @ (posedge slow_clk or posedge rst)
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            fill   <= '0;
        end
        else begin
            if (do_push)
                wr_ptr <= wr_ptr + 1'b1;

            if (do_pop)
                rd_ptr <= rd_ptr + 1'b1;

            // Push and pop together leave the level alone
            case ({do_push, do_pop})
                2'b10:   fill <= fill + 1'b1;
                2'b01:   fill <= fill - 1'b1;
                default: ;
            endcase
        end

    // Storage
    always_ff @ (posedge slow_clk)
        if (do_push)
            mem[wr_ptr] <= push_data;

    assign head  = mem[rd_ptr];

    assign empty = (fill == '0);
    assign full  = (fill == w_count'(fifo_depth));
    assign count = fill;

endmodule

`default_nettype wire

/* verilog/power_pipeline.sv */
`default_nettype none

module power_pipeline
# (
    parameter int w_operand = pow_types_pkg::w_operand
)
(
    input  logic                         slow_clk,
    input  logic                         rst,

    input  logic                         drain_en,
    input  pow_types_pkg::pow_request_t  head,
    input  logic                         empty,
    output logic                         pop,

    output pow_types_pkg::pow_result_t   result,
    output logic                         result_valid
);

    localparam int n_stages = 4;
    localparam int w_value  = 5 * w_operand;

    // Index 0 is the operand register, 1 to 4 the multiply stages
    logic                      [n_stages:0] valid_q;
    pow_types_pkg::pow_opcode_e             op_q   [0:n_stages];
    logic [w_operand - 1:0]                 opnd_q [0:n_stages];
    logic [w_value   - 1:0]                 prod_q [0:n_stages];

    // Never stalls, so drain whenever there is work and we may
    assign pop = drain_en && !empty;

    // --------------------------------------------------
    // Valid flags
    // --------------------------------------------------

    always_ff @ (posedge slow_clk or posedge rst)
        if (rst)
            valid_q <= '0;
        else
            valid_q <= {valid_q[n_stages - 1:0], pop};

    // --------------------------------------------------
    // Operand register and multiply stages
    // --------------------------------------------------

    always_ff @ (posedge slow_clk) begin
        if (pop) begin
            op_q   [0] <= head.opcode;
            opnd_q [0] <= head.operand;
            // Running product starts at the operand itself
            prod_q [0] <= w_value'(head.operand);
        end

        for (int k = 1; k <= n_stages; k++) begin
            op_q   [k] <= op_q   [k - 1];
            opnd_q [k] <= opnd_q [k - 1];

            // Stage k lifts x^k to x^(k+1) while the exponent asks for more
            if (3'(k) < pow_types_pkg::pow_exponent(op_q[k - 1]))
                prod_q[k] <= prod_q[k - 1] * w_value'(opnd_q[k - 1]);
            else
                prod_q[k] <= prod_q[k - 1];
        end
    end

    // Last stage feeds the result port
    assign result.opcode  = op_q   [n_stages];
    assign result.operand = opnd_q [n_stages];
    assign result.value   = prod_q [n_stages];
    assign result_valid   = valid_q[n_stages];

endmodule

`default_nettype wire

/* verilog/pow_subsystem.sv */
`default_nettype none

module pow_subsystem
# (
    parameter int w_operand  = pow_types_pkg::w_operand,
    parameter int fifo_depth = 4
)
(
    input  logic                        slow_clk,
    input  logic                        rst,

    input  apb_pkg::apb_req_t           apb_req,
    output apb_pkg::apb_rsp_t           apb_rsp,

    input  logic                        drain_en,
    output pow_types_pkg::pow_result_t  result,
    output logic                        result_valid
);

    localparam int w_count = $clog2(fifo_depth) + 1;

    // Port to FIFO
    logic                         push;
    pow_types_pkg::pow_request_t  push_data;
    logic                         full;
    logic [w_count - 1:0]         count;

    // FIFO to pipeline
    pow_types_pkg::pow_request_t  head;
    logic                         empty;
    logic                         pop;

    // --------------------------------------------------
    // Request path
    // --------------------------------------------------

    apb_request_port # (.w_operand (w_operand), .fifo_depth (fifo_depth)) i_apb_request_port
    (
        .slow_clk  ( slow_clk  ),
        .rst       ( rst       ),
        .apb_req   ( apb_req   ),
        .apb_rsp   ( apb_rsp   ),
        .full      ( full      ),
        .count     ( count     ),
        .push      ( push      ),
        .push_data ( push_data )
    );

    request_fifo # (.w_operand (w_operand), .fifo_depth (fifo_depth)) i_request_fifo
    (
        .slow_clk  ( slow_clk  ),
        .rst       ( rst       ),
        .push      ( push      ),
        .push_data ( push_data ),
        .pop       ( pop       ),
        .head      ( head      ),
        .empty     ( empty     ),
        .full      ( full      ),
        .count     ( count     )
    );

    // Compute path
    power_pipeline # (.w_operand (w_operand)) i_power_pipeline
    (
        .slow_clk     ( slow_clk     ),
        .rst          ( rst          ),
        .drain_en     ( drain_en     ),
        .head         ( head         ),
        .empty        ( empty        ),
        .pop          ( pop          ),
        .result       ( result       ),
        .result_valid ( result_valid )
    );

endmodule

`default_nettype wire

/* tb/tb_pow_subsystem.sv */
`default_nettype none

module tb_pow_subsystem;

    localparam int w_operand     = pow_types_pkg::w_operand;
    localparam int fifo_depth    = 4;
    localparam int w_count       = $clog2(fifo_depth) + 1;
    localparam int w_value       = 5 * w_operand;
    localparam int ready_timeout = 50;
    localparam int drain_timeout = 300;

    logic                        slow_clk;
    logic                        rst;
    apb_pkg::apb_req_t           apb_req;
    apb_pkg::apb_rsp_t           apb_rsp;
    logic                        drain_en;
    pow_types_pkg::pow_result_t  result;
    logic                        result_valid;

    pow_types_pkg::pow_result_t  exp_q [$];
    logic [31:0]                 rng_state      = 32'he70c;
    int                          model_fill     = 0;
    int                          mismatch_count = 0;
    int                          other_count    = 0;
    logic                        aborted        = 1'b0;

    pow_subsystem # (.w_operand (w_operand), .fifo_depth (fifo_depth)) i_pow_subsystem
    (
        .slow_clk     ( slow_clk     ),
        .rst          ( rst          ),
        .apb_req      ( apb_req      ),
        .apb_rsp      ( apb_rsp      ),
        .drain_en     ( drain_en     ),
        .result       ( result       ),
        .result_valid ( result_valid )
    );

    initial begin
        slow_clk = 1'b0;
        forever #4 slow_clk = ~slow_clk;
    end

    // --------------------------------------------------
    // Random numbers and reference model
    // --------------------------------------------------

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // Operand raised to 2, 3, 4 or 5
    function automatic logic [w_value - 1:0] model_power(input logic [w_operand - 1:0] base,
                                                        input pow_types_pkg::pow_opcode_e op);
        int                   exponent;
        logic [w_value - 1:0] acc;
        case (op)
            pow_types_pkg::op_square: exponent = 2;
            pow_types_pkg::op_cube:   exponent = 3;
            pow_types_pkg::op_fourth: exponent = 4;
            default:                  exponent = 5;
        endcase
        acc = w_value'(1);
        for (int i = 0; i < exponent; i++)
            acc = acc * w_value'(base);
        return acc;
    endfunction

    // --------------------------------------------------
    // Compare tasks
    // --------------------------------------------------

    task automatic check_result(input pow_types_pkg::pow_result_t expected,
                                input pow_types_pkg::pow_result_t actual);
        if (actual !== expected) begin
            mismatch_count++;
            $display("[FAIL] %0t: result expected op %0d operand %0d value %0d, got %0d %0d %0d",
                     $time, expected.opcode, expected.operand, expected.value,
                     actual.opcode, actual.operand, actual.value);
        end
    endtask

    task automatic check_status(input logic [w_count - 1:0] expected,
                                input logic [w_count - 1:0] actual);
        if (actual !== expected) begin
            mismatch_count++;
            $display("[FAIL] %0t: status count expected %0d, got %0d", $time, expected, actual);
        end
    endtask

    task automatic check_slverr(input logic expected, input logic actual);
        if (actual !== expected) begin
            mismatch_count++;
            $display("[FAIL] %0t: pslverr expected %0b, got %0b", $time, expected, actual);
        end
    endtask

    task automatic check_ready(input logic expected, input logic actual);
        if (actual !== expected) begin
            mismatch_count++;
            $display("[FAIL] %0t: pready expected %0b, got %0b", $time, expected, actual);
        end
    endtask

    // Every result must match the oldest accepted request
    always @(negedge slow_clk) begin
        if (!rst && result_valid) begin
            if (exp_q.size() == 0) begin
                other_count++;
                $display("Result appeared at time %0t with no request outstanding", $time);
            end
            else begin
                check_result(exp_q.pop_front(), result);
            end
        end
    end

    // --------------------------------------------------
    // APB transfers
    // --------------------------------------------------

    task automatic apb_transfer(input logic write, input logic [3:0] addr,
                                input logic [31:0] wdata,
                                output logic [31:0] rdata, output logic slverr);
        apb_pkg::apb_req_t req;
        int                waited;
        rdata  = '0;
        slverr = 1'b0;
        req    = '0;
        if (aborted)
            return;
        req.psel   = 1'b1;
        req.pwrite = write;
        req.paddr  = addr;
        req.pwdata = wdata;
        @(posedge slow_clk);
        apb_req <= req;
        req.penable = 1'b1;
        @(posedge slow_clk);
        apb_req <= req;
        waited = 0;
        @(negedge slow_clk);
        while (!apb_rsp.pready && waited < ready_timeout) begin
            @(negedge slow_clk);
            waited++;
        end
        if (apb_rsp.pready) begin
            rdata  = apb_rsp.prdata;
            slverr = apb_rsp.pslverr;
        end
        else begin
            aborted = 1'b1;
            other_count++;
            $display("APB transfer to address %h never completed, pready stayed low", addr);
        end
        @(posedge slow_clk);
        apb_req <= '0;
    endtask

    // Random opcode and operand with the model entry added on completion
    task automatic write_request();
        pow_types_pkg::pow_result_t expected;
        logic [31:0]                r;
        logic [31:0]                rdata;
        logic                       slverr;
        r = next_rand();
        expected.opcode  = pow_types_pkg::pow_opcode_e'(r[1:0]);
        expected.operand = r[8 +: w_operand];
        expected.value   = model_power(expected.operand, expected.opcode);
        apb_transfer(1'b1, apb_pkg::addr_request,
                     (32'(expected.operand) << 2) | 32'(expected.opcode), rdata, slverr);
        if (aborted)
            return;
        check_slverr(1'b0, slverr);
        exp_q.push_back(expected);
        model_fill++;
    endtask

    task automatic read_status();
        logic [31:0] rdata;
        logic        slverr;
        apb_transfer(1'b0, apb_pkg::addr_status, 32'd0, rdata, slverr);
        if (aborted)
            return;
        check_slverr(1'b0, slverr);
        check_status(w_count'(model_fill), rdata[w_count - 1:0]);
    endtask

    task automatic wait_drained();
        int waited;
        waited = 0;
        while (!aborted && exp_q.size() != 0 && waited < drain_timeout) begin
            @(posedge slow_clk);
            waited++;
        end
        if (!aborted && exp_q.size() != 0) begin
            aborted = 1'b1;
            other_count++;
            $display("%0d expected results never arrived", exp_q.size());
        end
    endtask

    // Empty FIFO, then hold it so the fill level is known
    task automatic stop_drain();
        wait_drained();
        @(posedge slow_clk);
        drain_en <= 1'b0;
        model_fill = 0;
    endtask

    // --------------------------------------------------
    // Test phases
    // --------------------------------------------------

    // Short bursts stay below fifo_depth so a held FIFO never blocks
    task automatic random_traffic(input int n_bursts);
        logic held;
        int   n_writes;
        for (int b = 0; b < n_bursts && !aborted; b++) begin
            held = (next_rand() % 32'd4) == 32'd0;
            if (held)
                stop_drain();
            n_writes = 1 + int'(next_rand() % 32'(fifo_depth - 1));
            for (int i = 0; i < n_writes && !aborted; i++) begin
                repeat (int'(next_rand() % 32'd4)) @(posedge slow_clk);
                write_request();
                if (held)
                    read_status();
            end
            @(posedge slow_clk);
            drain_en <= 1'b1;
        end
    endtask

    task automatic fill_and_block();
        int hold;
        stop_drain();
        for (int i = 0; i < fifo_depth; i++) begin
            write_request();
            read_status();
        end
        hold = 2 + int'(next_rand() % 32'd8);
        fork
            write_request();
            begin
                // Skip idle and setup, the wait states are in the access phase
                repeat (2) @(posedge slow_clk);
                repeat (hold) begin
                    @(negedge slow_clk);
                    check_ready(1'b0, apb_rsp.pready);
                end
                @(posedge slow_clk);
                drain_en <= 1'b1;
            end
        join
    endtask

    task automatic illegal_accesses(input int n);
        logic [31:0] r;
        logic [31:0] rdata;
        logic [3:0]  addr;
        logic        write;
        logic        slverr;
        stop_drain();
        for (int i = 0; i < n && !aborted; i++) begin
            r     = next_rand();
            write = r[2];
            addr  = r[7:4];
            if (r[1:0] == 2'd0) begin
                write = 1'b1;
                addr  = apb_pkg::addr_status;
            end
            else if (r[1:0] == 2'd1) begin
                write = 1'b0;
                addr  = apb_pkg::addr_request;
            end
            else if (addr == apb_pkg::addr_request || addr == apb_pkg::addr_status) begin
                addr = addr + 4'h1;
            end
            apb_transfer(write, addr, next_rand(), rdata, slverr);
            if (!aborted)
                check_slverr(1'b1, slverr);
        end
        // Nothing may have been queued
        read_status();
        @(posedge slow_clk);
        drain_en <= 1'b1;
    endtask

    initial begin
        rst      = 1'b1;
        apb_req  = '0;
        drain_en = 1'b0;
        repeat (2) @(posedge slow_clk);
        rst <= 1'b0;

        // Quiet after reset, and an empty FIFO
        repeat (4) @(posedge slow_clk);
        read_status();

        @(posedge slow_clk);
        drain_en <= 1'b1;
        random_traffic(30);
        fill_and_block();
        illegal_accesses(12);
        wait_drained();

        // Any late result here is a stray
        repeat (20) @(posedge slow_clk);

        $display("Errors: %0d mismatches, %0d other failures", mismatch_count, other_count);
        if (mismatch_count == 0 && other_count == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

/* list.f */
verilog/pow_types_pkg.sv
verilog/apb_pkg.sv
verilog/apb_request_port.sv
verilog/request_fifo.sv
verilog/power_pipeline.sv
verilog/pow_subsystem.sv
tb/tb_pow_subsystem.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the power unit testbench with Verilator

TOP=tb_pow_subsystem
BUILD_DIR=obj_dir
LOG=sim.log

cd "$(dirname "$0")" || exit 1

rm -rf "$BUILD_DIR"

verilator --binary --top-module "$TOP" -f list.f --Mdir "$BUILD_DIR" -o "$TOP"
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

"./$BUILD_DIR/$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation run exited with status $status"
    exit 1
fi

if grep -q "Simulation failed" "$LOG"; then
    echo "Testbench reported failure, see $LOG"
    exit 1
fi

echo "Testbench reported no failure"
exit 0
